// ==== source/cart_consts.svh ====
// Header addresses, region codes, quirk bit positions and bus widths
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Handshake and download bus widths
`define CART_ADDR_W 25
`define CART_WORD_W 16
`define CART_ID_W 64

// Product ID words in the cartridge header
`define HDR_ID_FIRST 'h182
`define HDR_ID_LAST 'h18A
// ID is complete by the time this word passes
`define HDR_ID_CHECK 'h18C

// Region letter words
`define HDR_REGION_A 'h1F0
`define HDR_REGION_B 'h1F2

// First word after the header
`define HDR_END 'h200

// Console region codes
`define REGION_JP 2'd0
`define REGION_US 2'd1
`define REGION_EU 2'd2

// Bit positions in the quirk vector
`define QUIRK_SRAM 0
`define QUIRK_EEPROM 1
`define QUIRK_FIFO 2
`define QUIRK_SVP 3
`define QUIRK_N 4

`endif

// ==== source/cart_pkg.sv ====
// Cartridge intake types: address, word, ID, region, priority, quirk and write FSM state
package cart_pkg;

`include "cart_consts.svh"

	////////////////////////////////////////////////////////////
	// Bus payloads
	////////////////////////////////////////////////////////////

	// Byte address into the ROM store
	typedef logic [`CART_ADDR_W-1:0] cart_addr_t;

	// One download or ROM word
	typedef logic [`CART_WORD_W-1:0] cart_word_t;

	// Eight ASCII characters, first character in the top byte
	typedef logic [`CART_ID_W-1:0] cart_id_t;

	////////////////////////////////////////////////////////////
	// Region and compatibility
	////////////////////////////////////////////////////////////

	// JP, US or EU code
	typedef logic [1:0] region_t;

	// 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU
	typedef logic [1:0] prio_t;

	// One bit per quirk kind
	typedef logic [`QUIRK_N-1:0] quirk_t;

	// ROM write handshake FSM
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_REQ,
		WR_RELEASE
	} wr_state_t;

endpackage

// ==== source/dl_word_if.sv ====
// Download word bus interface with writer and scan modports
`timescale 1ns/10ps

interface dl_word_if
	import cart_pkg::*;
();

	// Download window and word strobe
	logic active;
	logic wr;

	// Word payload, valid with wr
	cart_addr_t addr;
	cart_word_t data;

	// Back-pressure toward the download source
	logic stall;

	// ROM writer holds off the source while a write is in flight
	modport writer (
		input active, wr, addr, data,
		output stall
	);

	// Header scanner only watches the stream
	modport scan (
		input active, wr, addr, data
	);

endinterface

// ==== source/hdr_region_if.sv ====
// Header region flag interface with producer and consumer modports
`timescale 1ns/10ps

interface hdr_region_if ();

	// Region letters seen in the header
	logic flag_j;
	logic flag_u;
	logic flag_e;

	// Whole header has passed
	logic ready;

	modport producer (
		output flag_j, flag_u, flag_e, ready
	);

	modport consumer (
		input flag_j, flag_u, flag_e, ready
	);

endinterface

// ==== source/rom_write_ctrl.sv ====
// ROM write controller: four-phase write handshake, download wait and ROM size capture
`timescale 1ns/10ps

module rom_write_ctrl
	import cart_pkg::*;
(
	input logic clk_sys,
	input logic reset,
	dl_word_if.writer dl,
	output logic mem_req,
	input logic mem_ack,
	output cart_addr_t mem_addr,
	output cart_word_t mem_data,
	output cart_addr_t rom_size
);

	wr_state_t state;
	logic active_q;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: begin
					if (dl.active && dl.wr) begin
						state <= WR_REQ;
					end
				end
				// Hold req until the store takes the word
				WR_REQ: begin
					if (mem_ack) begin
						state <= WR_RELEASE;
					end
				end
				// Wait for ack to drop before the next word
				WR_RELEASE: begin
					if (!mem_ack) begin
						state <= WR_IDLE;
					end
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// Word capture, bytes swapped for the big-endian store
	always_ff @(posedge clk_sys) begin
		if (state == WR_IDLE && dl.active && dl.wr) begin
			mem_addr <= dl.addr;
			mem_data <= {dl.data[7:0], dl.data[15:8]};
		end
	end

	assign mem_req = (state == WR_REQ);

	// Source is held for the whole four-phase transfer
	assign dl.stall = (state != WR_IDLE);

	////////////////////////////////////////////////////////////
	// ROM size
	////////////////////////////////////////////////////////////

	// mem_addr still holds the last word written when active drops
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			rom_size <= '0;
		end else begin
			active_q <= dl.active;
			if (active_q && !dl.active) begin
				rom_size <= mem_addr + cart_addr_t'(2);
			end
		end
	end

endmodule

// ==== source/cart_header_scan.sv ====
// Cartridge header scanner: region letters, product ID assembly and quirk lookup
`timescale 1ns/10ps

`include "cart_consts.svh"

module cart_header_scan
	import cart_pkg::*;
(
	input logic clk_sys,
	input logic reset,
	dl_word_if.scan dl,
	hdr_region_if.producer hdr,
	output quirk_t quirks
);

	logic active_q;
	logic word_hit;
	logic [2:0] flags;
	logic hdr_ready;
	cart_id_t cart_id;

	// Flag vector is indexed by region code
	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		logic [2:0] f;
		f = '0;
		if (ch == "J") begin
			f[`REGION_JP] = 1'b1;
		end else if (ch == "U") begin
			f[`REGION_US] = 1'b1;
		end else if (ch >= "0" && ch <= "Z") begin
			f[`REGION_EU] = 1'b1;
		end
		return f;
	endfunction

	// Titles that need a compatibility quirk
	function automatic quirk_t id_quirk(input cart_id_t id);
		quirk_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				q[`QUIRK_SRAM] = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ":
				q[`QUIRK_EEPROM] = 1'b1;
			"T-89016 ":
				q[`QUIRK_FIFO] = 1'b1;
			"MK-1229 ", "G-7001  ":
				q[`QUIRK_SVP] = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	assign word_hit = dl.active && dl.wr;

	////////////////////////////////////////////////////////////
	// Product ID assembly
	////////////////////////////////////////////////////////////

	// First and last words carry one ID character each
	always_ff @(posedge clk_sys) begin
		if (word_hit) begin
			case (dl.addr)
				`HDR_ID_FIRST:     cart_id[63:56] <= dl.data[15:8];
				`HDR_ID_FIRST + 2: cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_FIRST + 4: cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_FIRST + 6: cart_id[23:8] <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_LAST:      cart_id[7:0] <= dl.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Flags, quirks and ready
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			flags <= '0;
			quirks <= '0;
			hdr_ready <= 1'b0;
		end else begin
			active_q <= dl.active;
			// New download starts from a clean slate
			if (dl.active && !active_q) begin
				flags <= '0;
				quirks <= '0;
			end
			if (!dl.active && active_q) begin
				hdr_ready <= 1'b0;
			end
			if (word_hit) begin
				if (dl.addr == `HDR_REGION_A) begin
					flags <= flags | letter_flags(dl.data[7:0]) | letter_flags(dl.data[15:8]);
				end
				// Only the low byte of the second word holds a letter
				if (dl.addr == `HDR_REGION_B) begin
					flags <= flags | letter_flags(dl.data[7:0]);
				end
				if (dl.addr == `HDR_ID_CHECK) begin
					quirks <= quirks | id_quirk(cart_id);
				end
				if (dl.addr == `HDR_END) begin
					hdr_ready <= 1'b1;
				end
			end
		end
	end

	assign hdr.flag_j = flags[`REGION_JP];
	assign hdr.flag_u = flags[`REGION_US];
	assign hdr.flag_e = flags[`REGION_EU];
	assign hdr.ready = hdr_ready;

endmodule

// ==== source/region_select.sv ====
// Region selector: priority pick from header flags and region set pulse
`timescale 1ns/10ps

`include "cart_consts.svh"

module region_select
	import cart_pkg::*;
(
	input logic clk_sys,
	input logic reset,
	hdr_region_if.consumer hdr,
	input logic region_auto,
	input prio_t region_prio,
	output region_t region_req,
	output logic region_set
);

	logic ready_q;
	logic [2:0] has;

	// First flagged region in the order, else the order's head
	function automatic region_t pick_region(input prio_t prio, input logic [2:0] flag);
		region_t order [0:2];
		case (prio)
			2'd0: order = '{`REGION_US, `REGION_EU, `REGION_JP};
			2'd1: order = '{`REGION_EU, `REGION_US, `REGION_JP};
			2'd2: order = '{`REGION_US, `REGION_JP, `REGION_EU};
			default: order = '{`REGION_JP, `REGION_US, `REGION_EU};
		endcase
		if (flag[order[0]]) begin
			return order[0];
		end else if (flag[order[1]]) begin
			return order[1];
		end else if (flag[order[2]]) begin
			return order[2];
		end
		return order[0];
	endfunction

	// Indexed by region code
	assign has = {hdr.flag_e, hdr.flag_u, hdr.flag_j};

	////////////////////////////////////////////////////////////
	// Request on header ready, release on its fall
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ready_q <= 1'b0;
			region_req <= `REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr.ready;
			if (hdr.ready && !ready_q && region_auto) begin
				region_req <= pick_region(region_prio, has);
				region_set <= 1'b1;
			end
			// Set lasts until the download ends
			if (!hdr.ready && ready_q) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

// ==== source/cart_intake_top.sv ====
// Cartridge intake top level: download bus, ROM writer, header scanner and region selector
`timescale 1ns/10ps

module cart_intake_top
	import cart_pkg::*;
(
	input logic clk_sys,
	input logic reset,

	// Download source
	input logic dl_active,
	input logic dl_wr,
	input cart_addr_t dl_addr,
	input cart_word_t dl_data,
	output logic dl_wait,

	// ROM store
	output logic mem_req,
	input logic mem_ack,
	output cart_addr_t mem_addr,
	output cart_word_t mem_data,
	output cart_addr_t rom_size,

	// Compatibility and region
	output quirk_t quirks,
	input logic region_auto,
	input prio_t region_prio,
	output region_t region_req,
	output logic region_set
);

	dl_word_if dl_bus ();
	hdr_region_if hdr_bus ();

	assign dl_bus.active = dl_active;
	assign dl_bus.wr = dl_wr;
	assign dl_bus.addr = dl_addr;
	assign dl_bus.data = dl_data;
	assign dl_wait = dl_bus.stall;

	rom_write_ctrl u_rom_write_ctrl (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl(dl_bus.writer),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.rom_size(rom_size)
	);

	cart_header_scan u_cart_header_scan (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl(dl_bus.scan),
		.hdr(hdr_bus.producer),
		.quirks(quirks)
	);

	region_select u_region_select (
		.clk_sys(clk_sys),
		.reset(reset),
		.hdr(hdr_bus.consumer),
		.region_auto(region_auto),
		.region_prio(region_prio),
		.region_req(region_req),
		.region_set(region_set)
	);

endmodule

// ==== tb/cart_intake_sva.sv ====
// Assertions on the ROM write handshake and the download wait
`timescale 1ns/10ps

module cart_intake_sva
	import cart_pkg::*;
(
	input logic clk_sys,
	input logic reset,
	input logic mem_req,
	input logic mem_ack,
	input cart_addr_t mem_addr,
	input cart_word_t mem_data,
	input logic dl_wait,
	input logic dl_wr
);

	// New request only after the last ack is gone
	req_after_ack_low: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req rose while mem_ack high");

	// Payload held for the whole request
	payload_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req && $past(mem_req)) |-> ($stable(mem_addr) && $stable(mem_data)))
		else $error("mem_addr or mem_data changed while mem_req high");

	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wait |-> !dl_wr)
		else $error("dl_wr pulsed while dl_wait high");

endmodule

bind rom_write_ctrl cart_intake_sva sva0 (
	.clk_sys(clk_sys),
	.reset(reset),
	.mem_req(mem_req),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr),
	.mem_data(mem_data),
	.dl_wait(dl.stall),
	.dl_wr(dl.wr)
);

// ==== tb/cart_intake_tb.sv ====
// Cartridge intake testbench: ROM store model, image builder, directed tests and timeout
`timescale 1ns/10ps

`include "cart_consts.svh"

module cart_intake_tb
	import cart_pkg::*;
();

	// 25 downloads of at most 0x120 words, 12 cycles worst case per word
	localparam int CYCLE_LIMIT = 25 * 'h120 * 12;

	logic clk_sys = 1'b0;
	logic reset;
	logic dl_active, dl_wr, dl_wait;
	cart_addr_t dl_addr, mem_addr, rom_size;
	cart_word_t dl_data, mem_data;
	logic mem_req, mem_ack;
	quirk_t quirks;
	logic region_auto, region_set;
	prio_t region_prio;
	region_t region_req, req_at_set;

	cart_word_t store [0:511];
	int wr_count;
	int cyc = 0;
	int hdr_end_cyc;
	int set_cyc;
	logic verdict_shown = 1'b0;
	logic slow_mem = 1'b0;
	logic [31:0] lcg_state = 32'h47d8_0800;

	cart_intake_top dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			verdict_shown = 1'b1;
			$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	// Watch the end-of-header write and the first cycle of region_set
	always @(posedge clk_sys) begin
		if (dl_active && dl_wr && dl_addr == `HDR_END) hdr_end_cyc = cyc;
		if (region_set && set_cyc < 0) begin
			set_cyc = cyc;
			req_at_set = region_req;
		end
	end

	final begin
		if (!verdict_shown) begin
			$display("Errors found");
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////////////////////////////////////////////
	// ROM store model
	////////////////////////////////////////////////////////////

	initial begin
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (mem_req && !mem_ack) begin
				delay = slow_mem ? 3 : int'((next_rand() >> 16) % 4);
				repeat (delay) @(posedge clk_sys);
				store[mem_addr[9:1]] = mem_data;
				wr_count = wr_count + 1;
				mem_ack <= 1'b1;
				do @(posedge clk_sys); while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	end

	// Source word for the image, ID and region letters in header order
	function automatic cart_word_t image_word(cart_addr_t a, logic [63:0] id, logic [15:0] letters);
		case (a)
			`HDR_ID_FIRST:     return {id[63:56], 8'h20};
			`HDR_ID_FIRST + 2: return {id[47:40], id[55:48]};
			`HDR_ID_FIRST + 4: return {id[31:24], id[39:32]};
			`HDR_ID_FIRST + 6: return {id[15:8], id[23:16]};
			`HDR_ID_LAST:      return {8'h20, id[7:0]};
			`HDR_REGION_A:     return letters;
			`HDR_REGION_B:     return 16'h2020;
			default:           return a[15:0] ^ 16'hc35a ^ {a[8:1], a[16:9]};
		endcase
	endfunction

	function automatic logic is_other_letter(logic [7:0] ch);
		return ch != "J" && ch != "U" && ch >= "0" && ch <= "Z";
	endfunction

	function automatic region_t expected_region(prio_t p, logic [15:0] letters);
		logic [2:0] flagged;
		region_t first, second, third;
		flagged[`REGION_JP] = letters[15:8] == "J" || letters[7:0] == "J";
		flagged[`REGION_US] = letters[15:8] == "U" || letters[7:0] == "U";
		flagged[`REGION_EU] = is_other_letter(letters[15:8]) || is_other_letter(letters[7:0]);
		case (p)
			2'd0: {first, second, third} = {`REGION_US, `REGION_EU, `REGION_JP};
			2'd1: {first, second, third} = {`REGION_EU, `REGION_US, `REGION_JP};
			2'd2: {first, second, third} = {`REGION_US, `REGION_JP, `REGION_EU};
			default: {first, second, third} = {`REGION_JP, `REGION_US, `REGION_EU};
		endcase
		if (flagged[first]) return first;
		if (flagged[second]) return second;
		if (flagged[third]) return third;
		return first;
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			verdict_shown = 1'b1;
			$display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Download driver
	////////////////////////////////////////////////////////////

	task automatic send_image(input logic [63:0] id, input logic [15:0] letters, input int len);
		hdr_end_cyc = -1;
		set_cyc = -1;
		wr_count = 0;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int a = 0; a < len; a += 2) begin
			@(posedge clk_sys);
			dl_wr <= 1'b1;
			dl_addr <= cart_addr_t'(a);
			dl_data <= image_word(cart_addr_t'(a), id, letters);
			@(posedge clk_sys);
			dl_wr <= 1'b0;
			@(negedge clk_sys);
			check_equal(dl_wait, 1, "dl_wait after dl_wr");
			while (dl_wait) @(negedge clk_sys);
			check_equal(mem_ack, 0, "mem_ack when dl_wait falls");
			check_equal(wr_count, a / 2 + 1, "words taken by store");
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_equal(region_set, 0, "region_set after download end");
	endtask

	task automatic test_image(input int len);
		cart_word_t src;
		for (int i = 0; i < 512; i++) begin
			store[i] = 'x;
		end
		send_image("T-081276", "JU", len);
		for (int a = 0; a < len; a += 2) begin
			src = image_word(cart_addr_t'(a), "T-081276", "JU");
			check_equal(store[a / 2], {src[7:0], src[15:8]}, $sformatf("store word %0h", a));
		end
		check_equal(rom_size, len, "rom_size");
	endtask

	task automatic test_quirks();
		logic [63:0] ids [6] = '{"T-081276", "XYZ-0001", "T-81406 ", "MK-1229 ",
			"MK-1215 ", "T-89016 "};
		int bits [6] = '{`QUIRK_SRAM, -1, `QUIRK_SRAM, `QUIRK_SVP, `QUIRK_EEPROM, `QUIRK_FIFO};
		for (int i = 0; i < 6; i++) begin
			send_image(ids[i], "U ", 'h204);
			check_equal(quirks, bits[i] < 0 ? 0 : (1 << bits[i]), $sformatf("quirks for id %0d", i));
		end
	endtask

	task automatic test_regions();
		logic [15:0] sets [4] = '{"JU", "E ", "  ", "U8"};
		for (int p = 0; p < 4; p++) begin
			for (int s = 0; s < 4; s++) begin
				@(posedge clk_sys);
				region_prio <= prio_t'(p);
				send_image("GM-00001", sets[s], 'h204);
				check_equal(req_at_set, expected_region(prio_t'(p), sets[s]), "region_req");
				check_equal(set_cyc - hdr_end_cyc, 2, "region_set latency");
			end
		end
	endtask

	task automatic test_manual_region();
		@(posedge clk_sys);
		region_auto <= 1'b0;
		send_image("GM-00002", "JU", 'h204);
		check_equal(set_cyc < 0, 1, "region_set stays low with region_auto low");
		@(posedge clk_sys);
		region_auto <= 1'b1;
	endtask

	initial begin
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		region_auto = 1'b1;
		region_prio = '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		test_image('h240);
		test_quirks();
		test_regions();
		test_manual_region();
		slow_mem = 1'b1;
		test_image('h240);
		verdict_shown = 1'b1;
		$display("No errors");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+source
source/cart_pkg.sv
source/dl_word_if.sv
source/hdr_region_if.sv
source/rom_write_ctrl.sv
source/cart_header_scan.sv
source/region_select.sv
source/cart_intake_top.sv
tb/cart_intake_sva.sv
tb/cart_intake_tb.sv

// ==== Makefile ====
# Verilator build and run for the cartridge intake testbench

VERILATOR ?= verilator
TOP ?= cart_intake_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= list.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
